/* hw/phase_monitor.sv */
`timescale 1ns/1ps

module phase_monitor
    import pi_pkg::*;
#(
    parameter int PM_WIN_LOG = 4
)(
    input  logic       clk_cdr,
    input  logic       rst,
    input  logic       en_pm,
    input  logic [1:0] sel_pm_sign,
    input  logic       cal_out,
    output pm_word_t   pm_out,
    output logic       pm_valid
);

    localparam int unsigned WIN_LEN = 2 ** PM_WIN_LOG;
    localparam int unsigned AW      = PM_WIN_LOG + 1;

    pm_state_t             state;
    logic [PM_WIN_LOG-1:0] win_cnt;
    logic [AW-1:0]         ones_acc;
    logic [AW-1:0]         ones_tot;
    logic [1:0]            mode;      // sign mode of this window.
    logic                  sample;
    logic                  last;
    pm_word_t              result;

    assign sample   = cal_out ^ mode[0];
    assign last     = &win_cnt;
    assign ones_tot = ones_acc + AW'(sample);

    // signed: ones - zeros = 2*ones - N.
    always_comb begin
        if (mode[1]) begin
            result = (pm_word_t'(ones_tot) << 1) - pm_word_t'(WIN_LEN);
        end else begin
            result = pm_word_t'(ones_tot);
        end
    end

    always_ff @(posedge clk_cdr) begin
        if (rst) begin
            state    <= PM_IDLE;
            win_cnt  <= '0;
            ones_acc <= '0;
            mode     <= '0;
            pm_out   <= '0;
            pm_valid <= 1'b0;
        end else begin
            pm_valid <= 1'b0;
            case (state)
                PM_IDLE: begin
                    if (en_pm) begin
                        state    <= PM_RUN;  // first sample next cycle.
                        win_cnt  <= '0;
                        ones_acc <= '0;
                        mode     <= sel_pm_sign;
                    end
                end
                PM_RUN: begin
                    if (!en_pm) begin
                        state <= PM_IDLE;  // abort, no result.
                    end else if (last) begin
                        pm_out   <= result;
                        pm_valid <= 1'b1;
                        win_cnt  <= '0;
                        ones_acc <= '0;
                        mode     <= sel_pm_sign;  // next window back to back.
                    end else begin
                        win_cnt  <= win_cnt + 1'b1;
                        ones_acc <= ones_tot;
                    end
                end
                default: begin
                    state <= PM_IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/pi_controller.sv */
`timescale 1ns/1ps

module pi_controller
    import pi_pkg::*;
#(
    parameter int PM_WIN_LOG = 4
)(
    input  logic       clk_cdr,
    input  logic       rst,
    input  logic       en_arb,
    input  unit_vec_t  arb_out,
    input  logic       en_ext_Qperi,
    input  unit_idx_t  ext_Qperi,
    input  ctl_t       ctl,
    input  logic       en_pm,
    input  logic [1:0] sel_pm_sign,
    input  logic       cal_out,

    output unit_idx_t  Qperi,
    output unit_idx_t  max_sel_mux,
    output unit_idx_t  sel_lead,
    output unit_idx_t  sel_lag,
    output unit_vec_t  en_mixer,
    output bld_therm_t thm_sel_bld,
    output pm_word_t   pm_out,
    output logic       pm_valid
);

    qperi_cal iqperi_cal (
        .clk_cdr(clk_cdr),
        .rst(rst),
        .en_arb(en_arb),
        .arb_out(arb_out),
        .en_ext_Qperi(en_ext_Qperi),
        .ext_Qperi(ext_Qperi),
        .qperi(Qperi),
        .max_sel_mux(max_sel_mux)
    );

    // Qperi and max_sel_mux also feed the encoder.
    pi_local_encoder ilocal_encoder (
        .clk_cdr(clk_cdr),
        .rst(rst),
        .ctl(ctl),
        .qperi(Qperi),
        .max_sel_mux(max_sel_mux),
        .sel_lead(sel_lead),
        .sel_lag(sel_lag),
        .en_mixer(en_mixer),
        .thm_sel_bld(thm_sel_bld)
    );

    phase_monitor #(
        .PM_WIN_LOG(PM_WIN_LOG)
    ) ipm (
        .clk_cdr(clk_cdr),
        .rst(rst),
        .en_pm(en_pm),
        .sel_pm_sign(sel_pm_sign),
        .cal_out(cal_out),
        .pm_out(pm_out),
        .pm_valid(pm_valid)
    );

endmodule

/* hw/pi_local_encoder.sv */
`timescale 1ns/1ps

module pi_local_encoder
    import pi_pkg::*;
(
    input  logic       clk_cdr,
    input  logic       rst,
    input  ctl_t       ctl,
    input  unit_idx_t  qperi,
    input  unit_idx_t  max_sel_mux,
    output unit_idx_t  sel_lead,
    output unit_idx_t  sel_lag,
    output unit_vec_t  en_mixer,
    output bld_therm_t thm_sel_bld
);

    localparam int unsigned UW  = $bits(unit_idx_t);
    localparam int unsigned CW  = $clog2(NCOARSE_STEPS);
    localparam int unsigned PW  = CW + UW;
    localparam int unsigned QSH = $clog2(NCOARSE_STEPS / 4);
    localparam int unsigned SW  = PW - QSH;

    logic [CW-1:0]       coarse;
    logic [NBLENDER-1:0] fine;
    logic [PW-1:0]       prod;

    // stage 1.
    logic [SW-1:0]       s1_scaled;
    unit_idx_t           s1_max;
    logic [NBLENDER-1:0] s1_fine;

    // stage 2 next values.
    unit_idx_t  lead_d;
    unit_idx_t  lag_d;
    unit_vec_t  mixer_d;
    bld_therm_t bld_d;

    assign coarse = ctl[NBIT-1 -: CW];
    assign fine   = ctl[NBLENDER-1:0];

    // c * 4*Qperi / NCOARSE_STEPS, i.e. c * Qperi / 8.
    assign prod = PW'(coarse) * PW'(qperi);

    always_ff @(posedge clk_cdr) begin
        if (rst) begin
            s1_scaled <= '0;
            s1_max    <= '0;
            s1_fine   <= '0;
        end else begin
            s1_scaled <= prod[PW-1:QSH];
            s1_max    <= max_sel_mux;  // same cycle as ctl.
            s1_fine   <= fine;
        end
    end

    always_comb begin
        if (s1_scaled > SW'(s1_max)) begin
            lead_d = s1_max;  // clamp to last mux.
        end else begin
            lead_d = unit_idx_t'(s1_scaled);
        end
    end

    // lag wraps back to the start of the period.
    assign lag_d = (lead_d == s1_max) ? '0 : lead_d + 1'b1;

    // units 0 through lead enabled.
    assign mixer_d = unit_vec_t'('1) >> (unit_idx_t'(NUNIT - 1) - lead_d);

    assign bld_d = (bld_therm_t'(1) << s1_fine) - 1'b1;

    always_ff @(posedge clk_cdr) begin
        if (rst) begin
            sel_lead    <= '0;
            sel_lag     <= '0;
            en_mixer    <= '0;
            thm_sel_bld <= '0;
        end else begin
            sel_lead    <= lead_d;
            sel_lag     <= lag_d;
            en_mixer    <= mixer_d;
            thm_sel_bld <= bld_d;
        end
    end

endmodule

/* hw/pi_pkg.sv */
package pi_pkg;

    // analog array dimensions.
    localparam int unsigned NBIT          = 9;   // phase code width.
    localparam int unsigned NUNIT         = 32;  // delay-chain units.
    localparam int unsigned NBLENDER      = 4;   // fine bits.
    localparam int unsigned NBLD          = 2 ** NBLENDER;
    localparam int unsigned NCOARSE_STEPS = 32;  // coarse steps per period.

    // monitor result width, as seen at the pad.
    localparam int unsigned PM_WORD_W = 20;

    // unit index, also used for Qperi and the mux selects.
    typedef logic [$clog2(NUNIT)-1:0] unit_idx_t;

    // one bit per delay-chain unit.
    typedef logic [NUNIT-1:0] unit_vec_t;

    typedef logic [NBIT-1:0] ctl_t;

    // blender legs, thermometer coded.
    typedef logic [NBLD-1:0] bld_therm_t;

    typedef logic [PM_WORD_W-1:0] pm_word_t;

    typedef enum logic {
        PM_IDLE = 1'b0,
        PM_RUN  = 1'b1
    } pm_state_t;

endpackage

/* hw/qperi_cal.sv */
`timescale 1ns/1ps

module qperi_cal
    import pi_pkg::*;
(
    input  logic      clk_cdr,
    input  logic      rst,
    input  logic      en_arb,
    input  unit_vec_t arb_out,
    input  logic      en_ext_Qperi,
    input  unit_idx_t ext_Qperi,
    output unit_idx_t qperi,
    output unit_idx_t max_sel_mux
);

    localparam int unsigned UW    = $bits(unit_idx_t);
    localparam int unsigned CNT_W = $clog2(NUNIT + 1);
    localparam int unsigned PW    = 2 * UW;
    // a quarter period spans NCOARSE_STEPS/4 coarse steps.
    localparam int unsigned QSH   = $clog2(NCOARSE_STEPS / 4);

    logic [CNT_W-1:0] ones;
    unit_idx_t        ones_sat;
    unit_idx_t        cap_q;      // last calibrated count.
    unit_idx_t        cap_d;
    unit_idx_t        qperi_d;
    logic [PW-1:0]    prod;
    logic [PW-QSH-1:0] scaled;
    unit_idx_t        max_d;

    // count ones over the sampled chain.
    always_comb begin
        ones = '0;
        for (int i = 0; i < NUNIT; i++) begin
            ones = ones + CNT_W'(arb_out[i]);
        end
    end

    // a full chain would read NUNIT, one past the index range.
    assign ones_sat = (ones > CNT_W'(NUNIT - 1)) ? unit_idx_t'(NUNIT - 1)
                                                 : unit_idx_t'(ones);

    assign cap_d   = en_arb ? ones_sat : cap_q;
    assign qperi_d = en_ext_Qperi ? ext_Qperi : cap_d;  // override wins.

    // last coarse step of the period, in units.
    assign prod   = PW'(qperi_d) * PW'(NCOARSE_STEPS - 1);
    assign scaled = prod[PW-1:QSH];

    always_comb begin
        if (scaled > (PW - QSH)'(NUNIT - 1)) begin
            max_d = unit_idx_t'(NUNIT - 1);
        end else begin
            max_d = unit_idx_t'(scaled);
        end
    end

    always_ff @(posedge clk_cdr) begin
        if (rst) begin
            cap_q       <= '0;
            qperi       <= '0;
            max_sel_mux <= '0;
        end else begin
            cap_q       <= cap_d;  // kept during override.
            qperi       <= qperi_d;
            max_sel_mux <= max_d;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh

LOG=sim.log
OBJ=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f src.f \
    --top-module pi_controller_tb \
    --Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ/Vpi_controller_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "All checks passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

/* sim/pi_controller_checker.sv */
`timescale 1ns/1ps

module pi_controller_checker
    import pi_pkg::*;
(
    input logic       clk_cdr,
    input logic       rst,
    input logic       en_pm,
    input logic       pm_valid,
    input bld_therm_t thm_sel_bld,
    input unit_idx_t  sel_lead,
    input unit_idx_t  max_sel_mux
);

    int unsigned fail_cnt = 0;  // failed assertions so far.

    // windows are at least two cycles long.
    a_valid_single: assert property (@(posedge clk_cdr) disable iff (rst)
        pm_valid |=> !pm_valid)
        else begin
            $error("pm_valid high on two consecutive cycles");
            fail_cnt++;
        end

    a_bld_therm: assert property (@(posedge clk_cdr) disable iff (rst)
        (thm_sel_bld & bld_therm_t'(thm_sel_bld + 1'b1)) == '0)
        else begin
            $error("thm_sel_bld is not a thermometer code");
            fail_cnt++;
        end

    // max_sel_mux as stage 1 registered it.
    a_lead_range: assert property (@(posedge clk_cdr) disable iff (rst)
        sel_lead <= $past(max_sel_mux, 2))
        else begin
            $error("sel_lead beyond max_sel_mux");
            fail_cnt++;
        end

    a_valid_needs_en: assert property (@(posedge clk_cdr) disable iff (rst)
        !$past(en_pm) |-> !pm_valid)
        else begin
            $error("pm_valid while en_pm was low");
            fail_cnt++;
        end

endmodule

bind pi_controller pi_controller_checker icheck (
    .clk_cdr(clk_cdr),
    .rst(rst),
    .en_pm(en_pm),
    .pm_valid(pm_valid),
    .thm_sel_bld(thm_sel_bld),
    .sel_lead(sel_lead),
    .max_sel_mux(max_sel_mux)
);

/* sim/pi_controller_tb.sv */
`timescale 1ns/1ps

module pi_controller_tb
    import pi_pkg::*;
();

    localparam int PM_WIN_LOG = 4;
    localparam int WIN        = 2 ** PM_WIN_LOG;
    localparam int MAX_CYCLES = 3000;

    logic       clk_cdr;
    logic       rst;
    logic       en_arb;
    unit_vec_t  arb_out;
    logic       en_ext_Qperi;
    unit_idx_t  ext_Qperi;
    ctl_t       ctl;
    logic       en_pm;
    logic [1:0] sel_pm_sign;
    logic       cal_out;

    unit_idx_t  Qperi;
    unit_idx_t  max_sel_mux;
    unit_idx_t  sel_lead;
    unit_idx_t  sel_lag;
    unit_vec_t  en_mixer;
    bld_therm_t thm_sel_bld;
    pm_word_t   pm_out;
    logic       pm_valid;

    int   cycle_cnt = 0;
    ctl_t codes[$];    // encoder stimulus.
    logic pm_bits[$];  // cal_out values in drive order.

    pi_controller #(
        .PM_WIN_LOG(PM_WIN_LOG)
    ) DUT (
        .clk_cdr(clk_cdr),
        .rst(rst),
        .en_arb(en_arb),
        .arb_out(arb_out),
        .en_ext_Qperi(en_ext_Qperi),
        .ext_Qperi(ext_Qperi),
        .ctl(ctl),
        .en_pm(en_pm),
        .sel_pm_sign(sel_pm_sign),
        .cal_out(cal_out),
        .Qperi(Qperi),
        .max_sel_mux(max_sel_mux),
        .sel_lead(sel_lead),
        .sel_lag(sel_lag),
        .en_mixer(en_mixer),
        .thm_sel_bld(thm_sel_bld),
        .pm_out(pm_out),
        .pm_valid(pm_valid)
    );

    initial begin
        clk_cdr = 1'b0;
        forever #2 clk_cdr = ~clk_cdr;
    end

    always @(posedge clk_cdr) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    always @(negedge clk_cdr) begin
        if (DUT.icheck.fail_cnt != 0) begin
            report_error("an assertion in the bound checker failed");
        end
    end

    // a full chain still reads as the last unit index.
    function automatic unit_idx_t expected_qperi(input unit_vec_t v);
        int n;
        n = 0;
        for (int i = 0; i < int'(NUNIT); i++) begin
            n += int'(v[i]);
        end
        return unit_idx_t'((n > 31) ? 31 : n);
    endfunction

    function automatic unit_idx_t expected_max(input unit_idx_t q);
        int m;
        m = (31 * int'(q)) / 8;
        return unit_idx_t'((m > 31) ? 31 : m);
    endfunction

    function automatic unit_idx_t expected_lead(input ctl_t code, input unit_idx_t q);
        int lead;
        int top;
        lead = (int'(code[8:4]) * int'(q)) / 8;
        top  = int'(expected_max(q));
        return unit_idx_t'((lead > top) ? top : lead);
    endfunction

    function automatic pm_word_t expected_pm(input int start, input logic [1:0] mode);
        int ones;
        ones = 0;
        for (int i = start; i < start + WIN; i++) begin
            ones += int'(pm_bits[i] ^ mode[0]);
        end
        if (mode[1]) begin
            return pm_word_t'(ones - (WIN - ones));  // ones minus zeros.
        end else begin
            return pm_word_t'(ones);
        end
    endfunction

    task automatic check_encoder(input ctl_t code, input unit_idx_t q);
        unit_idx_t  lead;
        unit_idx_t  lag;
        unit_vec_t  mixer;
        bld_therm_t bld;
        lead  = expected_lead(code, q);
        lag   = (lead == expected_max(q)) ? unit_idx_t'(0) : unit_idx_t'(lead + 1'b1);
        mixer = '0;
        for (int i = 0; i <= int'(lead); i++) begin
            mixer[i] = 1'b1;
        end
        bld = '0;
        for (int i = 0; i < int'(code[3:0]); i++) begin
            bld[i] = 1'b1;
        end
        assert (sel_lead == lead && sel_lag == lag)
            else report_error($sformatf("ctl %h: lead/lag %0d/%0d, expected %0d/%0d",
                                        code, sel_lead, sel_lag, lead, lag));
        assert (en_mixer == mixer && thm_sel_bld == bld)
            else report_error($sformatf("ctl %h: mixer %h bld %h, expected %h %h",
                                        code, en_mixer, thm_sel_bld, mixer, bld));
    endtask

    task automatic set_qperi(input int q);
        @(posedge clk_cdr);
        en_arb  <= 1'b1;
        arb_out <= unit_vec_t'((64'd1 << q) - 64'd1);
        @(posedge clk_cdr);
        en_arb  <= 1'b0;
        @(posedge clk_cdr);
    endtask

    // one code per cycle, outputs checked two cycles later.
    task automatic stream_codes(input unit_idx_t q);
        int n;
        n = codes.size();
        for (int i = 0; i < n + 2; i++) begin
            @(posedge clk_cdr);
            if (i < n) begin
                ctl <= codes[i];
            end
            @(negedge clk_cdr);
            if (i >= 2) begin
                check_encoder(codes[i-2], q);
            end
        end
    endtask

    task automatic run_monitor(input int nwin, input logic [1:0] mode, input bit zeros);
        logic b;
        pm_bits.delete();
        @(posedge clk_cdr);
        en_pm       <= 1'b1;
        sel_pm_sign <= mode;
        for (int j = 0; j <= nwin * WIN; j++) begin
            @(posedge clk_cdr);
            if (j < nwin * WIN) begin
                b = zeros ? 1'b0 : 1'(($urandom_range(1, 0)));
                cal_out <= b;
                pm_bits.push_back(b);
            end else begin
                en_pm <= 1'b0;
            end
            @(negedge clk_cdr);
            if (j > 0 && j % WIN == 0) begin
                assert (pm_valid)
                    else report_error($sformatf("no pm_valid after window %0d", j / WIN - 1));
                assert (pm_out == expected_pm(j - WIN, mode))
                    else report_error($sformatf("pm_out %h, expected %h", pm_out,
                                                expected_pm(j - WIN, mode)));
            end else begin
                assert (!pm_valid) else report_error("pm_valid inside a window");
            end
        end
        repeat (3) begin
            @(negedge clk_cdr);
            assert (!pm_valid) else report_error("pm_valid after en_pm dropped");
        end
    endtask

    task automatic test_reset_values();
        @(negedge clk_cdr);
        assert (Qperi == '0 && max_sel_mux == '0 && sel_lead == '0 && sel_lag == '0)
            else report_error("calibration or select outputs not zero after reset");
        assert (en_mixer == '0 && thm_sel_bld == '0 && pm_out == '0 && !pm_valid)
            else report_error("encoder or monitor outputs not zero after reset");
    endtask

    task automatic test_calibration();
        unit_vec_t v;
        unit_idx_t q_exp;
        unit_idx_t m_exp;
        for (int i = 0; i < 24; i++) begin
            if (i == 0) begin
                v = '1;
            end else if (i % 2 == 0) begin
                v = unit_vec_t'((64'd1 << $urandom_range(32, 0)) - 64'd1);
            end else begin
                v = $urandom();
            end
            q_exp = expected_qperi(v);
            m_exp = expected_max(q_exp);
            @(posedge clk_cdr);
            en_arb  <= 1'b1;
            arb_out <= v;
            @(posedge clk_cdr);
            en_arb  <= 1'b0;
            arb_out <= ~v;  // ignored while en_arb is low.
            @(negedge clk_cdr);
            assert (Qperi == q_exp && max_sel_mux == m_exp)
                else report_error($sformatf("Qperi/max %0d/%0d, expected %0d/%0d",
                                            Qperi, max_sel_mux, q_exp, m_exp));
            @(negedge clk_cdr);
            assert (Qperi == q_exp && max_sel_mux == m_exp)
                else report_error($sformatf("Qperi %0d not held, expected %0d", Qperi, q_exp));
        end
    endtask

    task automatic test_override();
        unit_idx_t ext;
        set_qperi(13);
        for (int i = 0; i < 8; i++) begin
            ext = unit_idx_t'($urandom_range(31, 0));
            @(posedge clk_cdr);
            en_ext_Qperi <= 1'b1;
            ext_Qperi    <= ext;
            @(posedge clk_cdr);
            @(negedge clk_cdr);
            assert (Qperi == ext && max_sel_mux == expected_max(ext))
                else report_error($sformatf("override Qperi %0d, expected %0d", Qperi, ext));
            @(posedge clk_cdr);
            en_ext_Qperi <= 1'b0;
            @(posedge clk_cdr);
            @(negedge clk_cdr);
            assert (Qperi == 5'd13 && max_sel_mux == expected_max(5'd13))
                else report_error($sformatf("released Qperi %0d, expected 13", Qperi));
        end
    endtask

    task automatic test_encoder_random();
        set_qperi(11);
        codes.delete();
        for (int i = 0; i < 200; i++) begin
            codes.push_back(ctl_t'($urandom()));
        end
        stream_codes(5'd11);
    endtask

    task automatic test_wrap_saturation();
        set_qperi(31);
        codes.delete();
        for (int c = 0; c < 32; c++) begin
            codes.push_back({5'(c), 4'($urandom_range(15, 0))});
        end
        stream_codes(5'd31);
        // last coarse step sits on the last mux, lag wraps.
        assert (sel_lead == 5'd31 && max_sel_mux == 5'd31 && sel_lag == '0)
            else report_error($sformatf("no wrap at lead %0d, lag %0d", sel_lead, sel_lag));
        set_qperi(0);
        stream_codes(5'd0);
        assert (sel_lead == '0 && sel_lag == '0 && en_mixer == unit_vec_t'(1))
            else report_error("selections not at unit 0 with Qperi 0");
    endtask

    task automatic test_monitor_signed_abort();
        run_monitor(1, 2'b10, 1'b1);
        assert (pm_out == pm_word_t'(-16))
            else report_error($sformatf("all-zero window gave %h", pm_out));
        run_monitor(2, 2'b11, 1'b0);
        @(posedge clk_cdr);
        en_pm       <= 1'b1;
        sel_pm_sign <= 2'b10;
        repeat (7) begin
            @(posedge clk_cdr);
            cal_out <= 1'($urandom_range(1, 0));
        end
        @(posedge clk_cdr);
        en_pm <= 1'b0;  // mid-window.
        repeat (WIN + 4) begin
            @(negedge clk_cdr);
            assert (!pm_valid) else report_error("pm_valid after an aborted window");
        end
        run_monitor(1, 2'b10, 1'b0);
    endtask

    initial begin
        void'($urandom(7998));
        rst          = 1'b1;
        en_arb       = 1'b0;
        arb_out      = '0;
        en_ext_Qperi = 1'b0;
        ext_Qperi    = '0;
        ctl          = '0;
        en_pm        = 1'b0;
        sel_pm_sign  = '0;
        cal_out      = 1'b0;
        repeat (3) @(posedge clk_cdr);
        rst <= 1'b0;
        test_reset_values();
        test_calibration();
        test_override();
        test_encoder_random();
        test_wrap_saturation();
        run_monitor(3, 2'b00, 1'b0);
        run_monitor(3, 2'b01, 1'b0);
        test_monitor_signed_abort();
        if (DUT.icheck.fail_cnt != 0) begin
            report_error("an assertion in the bound checker failed");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* src.f */
hw/pi_pkg.sv
hw/qperi_cal.sv
hw/pi_local_encoder.sv
hw/phase_monitor.sv
hw/pi_controller.sv
sim/pi_controller_checker.sv
sim/pi_controller_tb.sv
